//--- src.f
source/vec_isa_pkg.sv
source/instr_intake.sv
source/instr_decode_unit.sv
source/dispatch_stage.sv
source/decode_pipeline_top.sv
bench/decode_tb.sv

//--- Makefile
TOP = decode_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; \
	cat sim.log; \
	if grep -q "Done: errors found" sim.log; then \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf obj_dir sim.log

//--- bench/decode_cases.txt
# word dly ie io fs vr il fen fn mo ss rd rs1 rs2 imm  (word, fen, imm in hex; rest decimal)
# ie int_en, io int_op2_imm, fs float_op2_scalar, vr vector_reduce_en, il illegal
00221855 0 0 0 0 0 0 f 0 0 0 1 2 3 0000
0fffffff 3 0 0 0 0 0 f 3 0 0 31 31 31 0000
24853000 1 0 0 1 0 0 f 1 0 0 4 5 6 0000
28000800 0 0 0 1 0 0 f 2 0 0 0 0 1 0000
40e84800 2 0 0 0 0 0 1 0 0 2 7 8 9 0000
4d4b6000 0 0 0 0 0 0 1 3 0 2 10 11 12 0000
61ae7800 4 1 0 0 0 0 0 0 0 1 13 14 15 0000
6a119000 0 1 0 0 0 0 0 2 0 1 16 17 18 0000
a064beef 1 1 1 0 0 0 0 0 0 1 3 4 0 beef
aca68001 5 1 1 0 0 0 0 3 0 1 5 6 0 8001
a43f7fff 0 1 1 0 0 0 0 1 0 1 1 31 0 7fff
30220123 2 1 0 0 0 0 0 0 0 1 1 2 0 0000
3bdde000 0 1 0 0 0 0 0 2 0 1 30 29 28 0000
3c432000 1 1 0 0 0 0 0 3 0 1 2 3 4 0000
c0011000 0 1 0 0 0 0 0 1 0 0 0 1 2 0000
cd2a5800 3 1 0 0 0 0 0 1 0 0 9 10 11 0000
b29507ff 0 0 0 0 0 0 0 0 1 0 20 21 0 0000
f2d7c000 2 0 0 0 0 0 0 0 2 0 22 23 24 0000
bf3a0000 0 0 0 0 0 0 0 0 3 0 25 26 0 0000
ff7ce800 1 0 0 0 0 0 0 0 4 0 27 28 29 0000
80c01234 0 0 0 0 0 0 0 0 0 3 6 0 0 1234
84e1ffff 4 0 0 0 0 0 0 0 0 4 7 1 0 ffff
91095000 0 0 0 0 1 0 f 0 0 2 8 9 10 0000
10212800 1 0 0 0 0 1 0 0 0 0 1 1 5 0000
88000000 0 0 0 0 0 1 0 0 0 0 0 0 0 0000
e0620800 2 0 0 0 0 1 0 0 0 0 3 2 1 0000
5000ffff 0 0 0 0 0 1 0 0 0 0 0 0 31 0000

//--- bench/decode_tb.sv
`timescale 1ns/100ps

module decode_tb;

    import vec_isa_pkg::*;

    localparam int MAX_CASES = 64;

    logic                       clk;
    logic                       reset;
    logic                       in_req;
    instr_word_t                in_data;
    logic                       in_ack;
    logic                       out_req;
    logic                       out_ack;
    logic                       int_en;
    logic                       int_op2_imm;
    logic                       float_op2_scalar;
    logic                       vector_reduce_en;
    logic                       illegal;
    logic [NUM_FLOAT_LANES-1:0] float_en;
    alu_func_t                  alu_func;
    mem_op_t                    mem_op;
    scalar_sel_t                scalar_sel;
    reg_idx_t                   rd;
    reg_idx_t                   rs1;
    reg_idx_t                   rs2;
    logic [15:0]                imm;

    // Case table.
    instr_word_t                case_word [MAX_CASES];
    int                         case_delay [MAX_CASES];
    logic [4:0]                 exp_flags [MAX_CASES]; // {ie, io, fs, vr, il}.
    logic [NUM_FLOAT_LANES-1:0] exp_float_en [MAX_CASES];
    alu_func_t                  exp_func [MAX_CASES];
    mem_op_t                    exp_mem [MAX_CASES];
    scalar_sel_t                exp_sel [MAX_CASES];
    reg_idx_t                   exp_rd [MAX_CASES];
    reg_idx_t                   exp_rs1 [MAX_CASES];
    reg_idx_t                   exp_rs2 [MAX_CASES];
    logic [15:0]                exp_imm [MAX_CASES];

    int   num_cases;
    int   cases_loaded;
    int   cur_case;
    int   results_seen;
    int   mismatch_errors;
    int   other_errors;
    int   seed;

    logic [47:0] out_fields;
    logic [47:0] prev_fields;
    logic        prev_in_ack;
    logic        prev_in_req;
    logic        prev_out_req;

    decode_pipeline_top dut (.*);

    always #20 clk = ~clk;

    assign out_fields = {int_en, int_op2_imm, float_op2_scalar, vector_reduce_en, illegal,
                         float_en, alu_func, mem_op, scalar_sel, rd, rs1, rs2, imm};

    // ########################################
    // Compare tasks.
    task automatic check_bits(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: case %0d %s expected %h, got %h",
                     $time, cur_case, name, exp, act);
            mismatch_errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: case %0d %s expected %0d, got %0d",
                     $time, cur_case, name, exp, act);
            mismatch_errors++;
        end
    endtask

    task automatic check_func(input string name, input alu_func_t exp, input alu_func_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: case %0d %s expected %0d, got %0d",
                     $time, cur_case, name, exp, act);
            mismatch_errors++;
        end
    endtask

    task automatic check_mem(input string name, input mem_op_t exp, input mem_op_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: case %0d %s expected %0d, got %0d",
                     $time, cur_case, name, exp, act);
            mismatch_errors++;
        end
    endtask

    task automatic check_sel(input string name, input scalar_sel_t exp, input scalar_sel_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: case %0d %s expected %0d, got %0d",
                     $time, cur_case, name, exp, act);
            mismatch_errors++;
        end
    endtask

    task automatic compare_result(input int idx);
        check_bits("int_en", 32'(exp_flags[idx][4]), 32'(int_en));
        check_bits("int_op2_imm", 32'(exp_flags[idx][3]), 32'(int_op2_imm));
        check_bits("float_op2_scalar", 32'(exp_flags[idx][2]), 32'(float_op2_scalar));
        check_bits("vector_reduce_en", 32'(exp_flags[idx][1]), 32'(vector_reduce_en));
        check_bits("illegal", 32'(exp_flags[idx][0]), 32'(illegal));
        check_bits("float_en", 32'(exp_float_en[idx]), 32'(float_en));
        check_func("alu_func", exp_func[idx], alu_func);
        check_mem("mem_op", exp_mem[idx], mem_op);
        check_sel("scalar_sel", exp_sel[idx], scalar_sel);
        check_reg("rd", exp_rd[idx], rd);
        check_reg("rs1", exp_rs1[idx], rs1);
        check_reg("rs2", exp_rs2[idx], rs2);
        check_bits("imm", 32'(exp_imm[idx]), 32'(imm));
    endtask

    // ########################################
    // Case file.
    task automatic load_cases();
        int          fd;
        int          got;
        string       line;
        logic [31:0] t_word;
        int          t_dly, t_ie, t_io, t_fs, t_vr, t_il, t_fen;
        int          t_fn, t_mo, t_ss, t_rd, t_rs1, t_rs2, t_imm;
        fd = $fopen("bench/decode_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file bench/decode_cases.txt");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            got = $sscanf(line, "%h %d %b %b %b %b %b %h %d %d %d %d %d %d %h",
                          t_word, t_dly, t_ie, t_io, t_fs, t_vr, t_il, t_fen,
                          t_fn, t_mo, t_ss, t_rd, t_rs1, t_rs2, t_imm);
            if (got != 15 || num_cases >= MAX_CASES) begin
                $display("Skipped a malformed or surplus case line: %s", line);
                other_errors++;
                continue;
            end
            case_word[num_cases]    = t_word;
            case_delay[num_cases]   = t_dly;
            exp_flags[num_cases]    = {t_ie[0], t_io[0], t_fs[0], t_vr[0], t_il[0]};
            exp_float_en[num_cases] = t_fen[NUM_FLOAT_LANES-1:0];
            exp_func[num_cases]     = alu_func_t'(t_fn[1:0]);
            exp_mem[num_cases]      = mem_op_t'(t_mo[2:0]);
            exp_sel[num_cases]      = scalar_sel_t'(t_ss[2:0]);
            exp_rd[num_cases]       = t_rd[4:0];
            exp_rs1[num_cases]      = t_rs1[4:0];
            exp_rs2[num_cases]      = t_rs2[4:0];
            exp_imm[num_cases]      = t_imm[15:0];
            num_cases++;
        end
        $fclose(fd);
    endtask

    // ########################################
    // Handshake drivers.
    task automatic send_word(input instr_word_t w);
        @(posedge clk);
        #2;
        in_data = w;
        in_req  = 1'b1;
        @(negedge clk);
        while (!in_ack) @(negedge clk);
        @(posedge clk);
        #2;
        in_req = 1'b0;
        @(negedge clk);
        while (in_ack) @(negedge clk);
    endtask

    task automatic take_result(input int idx, input int delay);
        @(negedge clk);
        while (!out_req) @(negedge clk);
        cur_case = idx;
        compare_result(idx);
        results_seen++;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #2;
        out_ack = 1'b1;
        @(negedge clk);
        while (out_req) @(negedge clk);
        @(posedge clk);
        #2;
        out_ack = 1'b0;
    endtask

    task automatic produce_all();
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < num_cases; i++) begin
                send_word(case_word[i]);
            end
        end
    endtask

    task automatic consume_all();
        int delay;
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < num_cases; i++) begin
                if (p == 0) begin
                    delay = case_delay[i];
                end else begin
                    delay = $unsigned($random(seed)) % 6;  // Second pass, random ack.
                end
                take_result(i, delay);
            end
        end
    endtask

    // ########################################
    // Protocol monitor.
    always @(negedge clk) begin
        if (!reset) begin
            if (in_ack && !prev_in_ack && !prev_in_req) begin
                $display("Protocol error at %0t: in_ack rose while in_req was low", $time);
                other_errors++;
            end
            if (out_req && prev_out_req && out_fields !== prev_fields) begin
                $display("Protocol error at %0t: output fields changed while out_req was high",
                         $time);
                other_errors++;
            end
        end
        prev_in_ack  = in_ack;
        prev_in_req  = in_req;
        prev_out_req = out_req;
        prev_fields  = out_fields;
    end

    initial begin
        wait (cases_loaded == 1);
        repeat (2 * num_cases * 40 + 200) @(posedge clk);
        $display("The run timed out before all results came back (%0d of %0d seen)",
                 results_seen, 2 * num_cases);
        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors + 1);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        in_req          = 1'b0;
        in_data         = '0;
        out_ack         = 1'b0;
        cases_loaded    = 0;
        num_cases       = 0;
        results_seen    = 0;
        cur_case        = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        seed            = 32'hac5b;
        prev_in_ack     = 1'b0;
        prev_in_req     = 1'b0;
        prev_out_req    = 1'b0;
        prev_fields     = '0;
        load_cases();
        cases_loaded = 1;

        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        if (in_ack !== 1'b0 || out_req !== 1'b0) begin
            $display("After reset in_ack or out_req was not low");
            other_errors++;
        end

        if (num_cases == 0) begin
            $display("No test cases were loaded");
            other_errors++;
        end else begin
            fork
                produce_all();
                consume_all();
            join
            repeat (10) begin
                @(negedge clk);
                if (out_req) begin
                    $display("An extra result appeared after the last case at %0t", $time);
                    other_errors++;
                end
            end
        end

        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- source/decode_pipeline_top.sv
`timescale 1ns/100ps

module decode_pipeline_top (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    in_req,
    input  vec_isa_pkg::instr_word_t                in_data,
    output logic                                    in_ack,
    output logic                                    out_req,
    input  logic                                    out_ack,
    output logic                                    int_en,
    output logic                                    int_op2_imm,
    output logic                                    float_op2_scalar,
    output logic                                    vector_reduce_en,
    output logic                                    illegal,
    output logic [vec_isa_pkg::NUM_FLOAT_LANES-1:0] float_en,
    output vec_isa_pkg::alu_func_t                  alu_func,
    output vec_isa_pkg::mem_op_t                    mem_op,
    output vec_isa_pkg::scalar_sel_t                scalar_sel,
    output vec_isa_pkg::reg_idx_t                   rd,
    output vec_isa_pkg::reg_idx_t                   rs1,
    output vec_isa_pkg::reg_idx_t                   rs2,
    output logic [15:0]                             imm
);

    import vec_isa_pkg::*;

    // Intake to decode.
    logic        word_valid;
    logic        word_take;
    instr_word_t word;

    // Decode to dispatch.
    logic                       dec_valid;
    logic                       dec_take;
    logic                       dec_int_en;
    logic                       dec_int_op2_imm;
    logic                       dec_float_op2_scalar;
    logic                       dec_vector_reduce_en;
    logic                       dec_illegal;
    logic [NUM_FLOAT_LANES-1:0] dec_float_en;
    alu_func_t                  dec_alu_func;
    mem_op_t                    dec_mem_op;
    scalar_sel_t                dec_scalar_sel;
    reg_idx_t                   dec_rd;
    reg_idx_t                   dec_rs1;
    reg_idx_t                   dec_rs2;
    logic [15:0]                dec_imm;

    instr_intake u_intake (.*);

    instr_decode_unit u_decode (
        .clk,
        .reset,
        .word_valid,
        .word,
        .word_take,
        .dec_valid,
        .dec_take,
        .int_en           (dec_int_en),
        .int_op2_imm      (dec_int_op2_imm),
        .float_op2_scalar (dec_float_op2_scalar),
        .vector_reduce_en (dec_vector_reduce_en),
        .illegal          (dec_illegal),
        .float_en         (dec_float_en),
        .alu_func         (dec_alu_func),
        .mem_op           (dec_mem_op),
        .scalar_sel       (dec_scalar_sel),
        .rd               (dec_rd),
        .rs1              (dec_rs1),
        .rs2              (dec_rs2),
        .imm              (dec_imm)
    );

    dispatch_stage u_dispatch (.*);

endmodule

//--- source/dispatch_stage.sv
`timescale 1ns/100ps

module dispatch_stage (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    dec_valid,
    output logic                                    dec_take,
    input  logic                                    out_ack,
    output logic                                    out_req,
    input  logic                                    dec_int_en,
    input  logic                                    dec_int_op2_imm,
    input  logic                                    dec_float_op2_scalar,
    input  logic                                    dec_vector_reduce_en,
    input  logic                                    dec_illegal,
    input  logic [vec_isa_pkg::NUM_FLOAT_LANES-1:0] dec_float_en,
    input  vec_isa_pkg::alu_func_t                  dec_alu_func,
    input  vec_isa_pkg::mem_op_t                    dec_mem_op,
    input  vec_isa_pkg::scalar_sel_t                dec_scalar_sel,
    input  vec_isa_pkg::reg_idx_t                   dec_rd,
    input  vec_isa_pkg::reg_idx_t                   dec_rs1,
    input  vec_isa_pkg::reg_idx_t                   dec_rs2,
    input  logic [15:0]                             dec_imm,
    output logic                                    int_en,
    output logic                                    int_op2_imm,
    output logic                                    float_op2_scalar,
    output logic                                    vector_reduce_en,
    output logic                                    illegal,
    output logic [vec_isa_pkg::NUM_FLOAT_LANES-1:0] float_en,
    output vec_isa_pkg::alu_func_t                  alu_func,
    output vec_isa_pkg::mem_op_t                    mem_op,
    output vec_isa_pkg::scalar_sel_t                scalar_sel,
    output vec_isa_pkg::reg_idx_t                   rd,
    output vec_isa_pkg::reg_idx_t                   rs1,
    output vec_isa_pkg::reg_idx_t                   rs2,
    output logic [15:0]                             imm
);

    logic ack_wait;  // Req dropped, ack not yet seen low.

    assign dec_take = dec_valid && !out_req && !ack_wait;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_req  <= 1'b0;
            ack_wait <= 1'b0;
        end else if (dec_take) begin
            out_req <= 1'b1;
        end else if (out_req && out_ack) begin
            out_req  <= 1'b0;
            ack_wait <= 1'b1;
        end else if (ack_wait && !out_ack) begin
            ack_wait <= 1'b0;     // Handshake closed.
        end
    end

    always_ff @(posedge clk) begin
        if (dec_take) begin
            int_en           <= dec_int_en;
            int_op2_imm      <= dec_int_op2_imm;
            float_op2_scalar <= dec_float_op2_scalar;
            vector_reduce_en <= dec_vector_reduce_en;
            illegal          <= dec_illegal;
            float_en         <= dec_float_en;
            alu_func         <= dec_alu_func;
            mem_op           <= dec_mem_op;
            scalar_sel       <= dec_scalar_sel;
            rd               <= dec_rd;
            rs1              <= dec_rs1;
            rs2              <= dec_rs2;
            imm              <= dec_imm;
        end
    end

    fields_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_req && $past(out_req) |-> $stable({int_en, int_op2_imm, float_op2_scalar,
            vector_reduce_en, illegal, float_en, alu_func, mem_op, scalar_sel,
            rd, rs1, rs2, imm})
    ) else $error("output fields changed under out_req");

endmodule

//--- source/instr_decode_unit.sv
`timescale 1ns/100ps

module instr_decode_unit (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    word_valid,
    input  vec_isa_pkg::instr_word_t                word,
    output logic                                    word_take,
    output logic                                    dec_valid,
    input  logic                                    dec_take,
    output logic                                    int_en,
    output logic                                    int_op2_imm,
    output logic                                    float_op2_scalar,
    output logic                                    vector_reduce_en,
    output logic                                    illegal,
    output logic [vec_isa_pkg::NUM_FLOAT_LANES-1:0] float_en,
    output vec_isa_pkg::alu_func_t                  alu_func,
    output vec_isa_pkg::mem_op_t                    mem_op,
    output vec_isa_pkg::scalar_sel_t                scalar_sel,
    output vec_isa_pkg::reg_idx_t                   rd,
    output vec_isa_pkg::reg_idx_t                   rs1,
    output vec_isa_pkg::reg_idx_t                   rs2,
    output logic [15:0]                             imm
);

    import vec_isa_pkg::*;

    opcode_t                    op;
    logic                       imm_form;
    logic                       nxt_int_en;
    logic                       nxt_int_op2_imm;
    logic                       nxt_float_op2_scalar;
    logic                       nxt_reduce_en;
    logic                       nxt_illegal;
    logic [NUM_FLOAT_LANES-1:0] nxt_float_en;
    alu_func_t                  nxt_alu_func;
    mem_op_t                    nxt_mem_op;
    scalar_sel_t                nxt_scalar_sel;

    assign op        = word.r_form.opcode;
    assign word_take = word_valid && (!dec_valid || dec_take); // Empty or emptying now.

    // ########################################
    // Opcode decode.
    always_comb begin
        imm_form             = 1'b0;
        nxt_int_en           = 1'b0;
        nxt_int_op2_imm      = 1'b0;
        nxt_float_op2_scalar = 1'b0;
        nxt_reduce_en        = 1'b0;
        nxt_illegal          = 1'b0;
        nxt_float_en         = '0;
        nxt_alu_func         = alu_func_t'(op[1:0]);
        nxt_mem_op           = MEM_NONE;
        nxt_scalar_sel       = SEL_NONE;

        case (op[5:2])
            CLS_VV: nxt_float_en = '1;
            CLS_VF: begin
                nxt_float_en         = '1;
                nxt_float_op2_scalar = 1'b1;
            end
            CLS_FF: begin
                nxt_float_en   = NUM_FLOAT_LANES'(1);   // Lane 0 only.
                nxt_scalar_sel = SEL_FLOAT;
            end
            CLS_II, CLS_LOGIC: begin
                nxt_int_en     = 1'b1;                  // Low bits pick not/and/or/xor for logic.
                nxt_scalar_sel = SEL_INT;
            end
            CLS_IMM: begin
                imm_form        = 1'b1;
                nxt_int_en      = 1'b1;
                nxt_int_op2_imm = 1'b1;
                nxt_scalar_sel  = SEL_INT;
            end
            CLS_BRANCH: begin
                nxt_int_en   = 1'b1;                    // Compare by subtraction.
                nxt_alu_func = FUNC_SUB;
            end
            default: begin
                nxt_alu_func = FUNC_ADD;
                case (op)
                    OP_S_LOAD:  nxt_mem_op = MEM_S_LOAD;
                    OP_S_STORE: nxt_mem_op = MEM_S_STORE;
                    OP_V_LOAD:  nxt_mem_op = MEM_V_LOAD;
                    OP_V_STORE: nxt_mem_op = MEM_V_STORE;
                    OP_S_WRITE_HIGH: begin
                        imm_form       = 1'b1;
                        nxt_scalar_sel = SEL_IMM_HIGH;
                    end
                    OP_S_WRITE_LOW: begin
                        imm_form       = 1'b1;
                        nxt_scalar_sel = SEL_IMM_LOW;
                    end
                    OP_V_REDUCE: begin
                        nxt_float_en   = '1;
                        nxt_reduce_en  = 1'b1;
                        nxt_scalar_sel = SEL_FLOAT;
                    end
                    default: nxt_illegal = 1'b1;
                endcase
            end
        endcase
    end

    // ########################################
    // Decode register.
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (word_take) begin
            dec_valid <= 1'b1;
        end else if (dec_take) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (word_take) begin
            int_en           <= nxt_int_en;
            int_op2_imm      <= nxt_int_op2_imm;
            float_op2_scalar <= nxt_float_op2_scalar;
            vector_reduce_en <= nxt_reduce_en;
            illegal          <= nxt_illegal;
            float_en         <= nxt_float_en;
            alu_func         <= nxt_alu_func;
            mem_op           <= nxt_mem_op;
            scalar_sel       <= nxt_scalar_sel;
            rd               <= word.r_form.rd;
            rs1              <= word.r_form.rs1;
            rs2              <= imm_form ? '0 : word.r_form.rs2;
            imm              <= imm_form ? word.i_form.imm : '0;
        end
    end

    mem_not_int: assert property (
        @(posedge clk) disable iff (reset)
        dec_valid |-> !(int_en && mem_op != MEM_NONE)
    ) else $error("int_en together with a memory op");

    illegal_quiet: assert property (
        @(posedge clk) disable iff (reset)
        dec_valid && illegal |-> !int_en && float_en == '0 && !vector_reduce_en
                                 && mem_op == MEM_NONE && scalar_sel == SEL_NONE
    ) else $error("illegal opcode with an enable set");

endmodule

//--- source/instr_intake.sv
`timescale 1ns/100ps

module instr_intake (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_req,
    input  vec_isa_pkg::instr_word_t in_data,
    output logic                     in_ack,
    output logic                     word_valid,
    output vec_isa_pkg::instr_word_t word,
    input  logic                     word_take
);

    logic capture;

    // New request, previous one fully released, holding register free.
    assign capture = in_req && !in_ack && !word_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_ack     <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            if (capture) begin
                in_ack <= 1'b1;            // Ack rises with the capture.
            end else if (!in_req) begin
                in_ack <= 1'b0;            // Producer let go of req.
            end

            if (capture) begin
                word_valid <= 1'b1;
            end else if (word_take) begin
                word_valid <= 1'b0;        // Decode took it.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            word <= in_data;
        end
    end

    // ########################################
    // Protocol checks.
    ack_follows_req: assert property (
        @(posedge clk) disable iff (reset)
        $rose(in_ack) |-> $past(in_req)
    ) else $error("in_ack rose without in_req");

    take_needs_word: assert property (
        @(posedge clk) disable iff (reset)
        word_take |-> word_valid
    ) else $error("word_take with empty intake");

endmodule

//--- source/vec_isa_pkg.sv
package vec_isa_pkg;

    localparam int NUM_FLOAT_LANES = 4;

    typedef logic [5:0] opcode_t;
    typedef logic [4:0] reg_idx_t;

    // ########################################
    // Opcode classes, taken from opcode bits 5:2.
    localparam logic [3:0] CLS_VV     = 4'b0000;
    localparam logic [3:0] CLS_VF     = 4'b0010;
    localparam logic [3:0] CLS_LOGIC  = 4'b0011;
    localparam logic [3:0] CLS_FF     = 4'b0100;
    localparam logic [3:0] CLS_II     = 4'b0110;
    localparam logic [3:0] CLS_IMM    = 4'b1010;
    localparam logic [3:0] CLS_BRANCH = 4'b1100;

    // ########################################
    // Decoded opcodes.
    localparam opcode_t OP_VV_ADD       = 6'b000000;
    localparam opcode_t OP_VV_SUB       = 6'b000001;
    localparam opcode_t OP_VV_MUL       = 6'b000010;
    localparam opcode_t OP_VV_DIV       = 6'b000011;
    localparam opcode_t OP_VF_ADD       = 6'b001000;
    localparam opcode_t OP_VF_SUB       = 6'b001001;
    localparam opcode_t OP_VF_MUL       = 6'b001010;
    localparam opcode_t OP_VF_DIV       = 6'b001011;
    localparam opcode_t OP_NOT          = 6'b001100;
    localparam opcode_t OP_AND          = 6'b001101;
    localparam opcode_t OP_OR           = 6'b001110;
    localparam opcode_t OP_XOR          = 6'b001111;
    localparam opcode_t OP_FF_ADD       = 6'b010000;
    localparam opcode_t OP_FF_SUB       = 6'b010001;
    localparam opcode_t OP_FF_MUL       = 6'b010010;
    localparam opcode_t OP_FF_DIV       = 6'b010011;
    localparam opcode_t OP_II_ADD       = 6'b011000;
    localparam opcode_t OP_II_SUB       = 6'b011001;
    localparam opcode_t OP_II_MUL       = 6'b011010;
    localparam opcode_t OP_II_DIV       = 6'b011011;
    localparam opcode_t OP_II_ADDI      = 6'b101000;
    localparam opcode_t OP_II_SUBI      = 6'b101001;
    localparam opcode_t OP_II_MULI      = 6'b101010;
    localparam opcode_t OP_II_DIVI      = 6'b101011;
    localparam opcode_t OP_BNE          = 6'b110000;
    localparam opcode_t OP_BG           = 6'b110001;
    localparam opcode_t OP_BL           = 6'b110010;
    localparam opcode_t OP_BGE          = 6'b110011;
    localparam opcode_t OP_S_WRITE_HIGH = 6'b100000;
    localparam opcode_t OP_S_WRITE_LOW  = 6'b100001;
    localparam opcode_t OP_V_REDUCE     = 6'b100100;
    localparam opcode_t OP_S_LOAD       = 6'b101100;
    localparam opcode_t OP_V_LOAD       = 6'b101111;
    localparam opcode_t OP_S_STORE      = 6'b111100;
    localparam opcode_t OP_V_STORE      = 6'b111111;

    // ########################################
    // Control fields.
    typedef enum logic [1:0] {FUNC_ADD, FUNC_SUB, FUNC_MUL, FUNC_DIV} alu_func_t;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_S_LOAD, MEM_S_STORE, MEM_V_LOAD, MEM_V_STORE
    } mem_op_t;

    typedef enum logic [2:0] {
        SEL_NONE, SEL_INT, SEL_FLOAT, SEL_IMM_HIGH, SEL_IMM_LOW
    } scalar_sel_t;

    // ########################################
    // Instruction word.
    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [10:0] spare;
    } r_form_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        logic [15:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } instr_word_t;

endpackage
